//--- Bender.yml
package:
  name: gb_cpu_core

sources:
  - src/gb_cpu_common_pkg.sv
  - src/gb_cpu_decode.sv
  - src/gb_cpu_alu.sv
  - src/gb_cpu_regfile.sv
  - src/gb_cpu_core.sv
  - target: test
    files:
      - tests/gb_cpu_core_checker.sv
      - tests/gb_cpu_core_tb.sv

//--- gb_cpu_core.f
src/gb_cpu_common_pkg.sv
src/gb_cpu_decode.sv
src/gb_cpu_alu.sv
src/gb_cpu_regfile.sv
src/gb_cpu_core.sv
tests/gb_cpu_core_checker.sv
tests/gb_cpu_core_tb.sv

//--- src/gb_cpu_alu.sv
module gb_cpu_alu (
    input  logic        clk,
    input  logic        reset,
    input  logic        dec_valid,
    input  logic        dec_alu,
    input  logic        dec_load,
    input  logic        dec_inc16,
    input  logic        dec_dec16,
    input  logic        dec_illegal,
    input  logic        dec_use_imm,
    input  logic [2:0]  dec_alu_op,
    input  logic [3:0]  dec_src,
    input  logic [3:0]  dec_dst,
    input  logic [1:0]  dec_pair,
    input  logic [1:0]  dec_len,
    input  logic [7:0]  dec_imm,
    input  logic [7:0]  a,
    input  logic [7:0]  f,
    input  logic [7:0]  b,
    input  logic [7:0]  c,
    input  logic [7:0]  d,
    input  logic [7:0]  e,
    input  logic [7:0]  h,
    input  logic [7:0]  l,
    input  logic [15:0] sp,
    output logic        ex_valid,
    output logic        ex_illegal,
    output logic        wr16_en,
    output logic        flags_en,
    output logic [3:0]  wr8_reg,
    output logic [7:0]  wr8_data,
    output logic [3:0]  flags,
    output logic [1:0]  wr16_pair,
    output logic [15:0] wr16_data,
    output logic [1:0]  ex_len
);

    logic [7:0]  reg_val;
    logic [7:0]  operand;
    logic [7:0]  result;
    logic [3:0]  flags_next;
    logic        carry_in;
    logic [4:0]  half;
    logic [8:0]  full;
    logic [15:0] pair_val;
    logic [15:0] pair_step;

    // Source register read
    always_comb begin
        case (dec_src)
            gb_cpu_common_pkg::REG_B: reg_val = b;
            gb_cpu_common_pkg::REG_C: reg_val = c;
            gb_cpu_common_pkg::REG_D: reg_val = d;
            gb_cpu_common_pkg::REG_E: reg_val = e;
            gb_cpu_common_pkg::REG_H: reg_val = h;
            gb_cpu_common_pkg::REG_L: reg_val = l;
            gb_cpu_common_pkg::REG_A: reg_val = a;
            default:                  reg_val = 8'h00;
        endcase
    end

    assign operand = dec_use_imm ? dec_imm : reg_val;

    always_comb begin
        // Only ADC and SBC take the old carry
        carry_in = (dec_alu_op == gb_cpu_common_pkg::ALU_ADC
                    || dec_alu_op == gb_cpu_common_pkg::ALU_SBC)
                   && f[4 + gb_cpu_common_pkg::FLAG_C];
        half       = 5'd0;
        full       = 9'd0;
        result     = a;
        flags_next = 4'h0;
        case (dec_alu_op)
            gb_cpu_common_pkg::ALU_ADD, gb_cpu_common_pkg::ALU_ADC: begin
                half = {1'b0, a[3:0]} + {1'b0, operand[3:0]} + 5'(carry_in);
                full = {1'b0, a} + {1'b0, operand} + 9'(carry_in);
            end
            gb_cpu_common_pkg::ALU_SUB, gb_cpu_common_pkg::ALU_SBC,
            gb_cpu_common_pkg::ALU_CP: begin
                // Bit 4 and bit 8 come out as borrows
                half = {1'b0, a[3:0]} - {1'b0, operand[3:0]} - 5'(carry_in);
                full = {1'b0, a} - {1'b0, operand} - 9'(carry_in);
                flags_next[gb_cpu_common_pkg::FLAG_N] = 1'b1;
            end
            gb_cpu_common_pkg::ALU_AND: begin
                result = a & operand;
                flags_next[gb_cpu_common_pkg::FLAG_H] = 1'b1;
            end
            gb_cpu_common_pkg::ALU_XOR: result = a ^ operand;
            gb_cpu_common_pkg::ALU_OR:  result = a | operand;
            default:                    result = a;
        endcase
        if (dec_alu_op < gb_cpu_common_pkg::ALU_AND || dec_alu_op == gb_cpu_common_pkg::ALU_CP) begin
            result = full[7:0];
            flags_next[gb_cpu_common_pkg::FLAG_H] = half[4];
            flags_next[gb_cpu_common_pkg::FLAG_C] = full[8];
        end
        flags_next[gb_cpu_common_pkg::FLAG_Z] = result == 8'h00;
    end

    // 16-bit step wraps on its own
    always_comb begin
        case (dec_pair)
            gb_cpu_common_pkg::PAIR_BC: pair_val = {b, c};
            gb_cpu_common_pkg::PAIR_DE: pair_val = {d, e};
            gb_cpu_common_pkg::PAIR_HL: pair_val = {h, l};
            default:                    pair_val = sp;
        endcase
    end

    assign pair_step = dec_dec16 ? pair_val - 16'd1 : pair_val + 16'd1;

    always_ff @(posedge clk) begin
        if (reset)
            ex_valid <= 1'b0;
        else
            ex_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_illegal <= dec_illegal;
            ex_len     <= dec_len;
            flags_en   <= dec_alu;
            flags      <= flags_next;
            wr16_en    <= dec_inc16 || dec_dec16;
            wr16_pair  <= dec_pair;
            wr16_data  <= pair_step;
            wr8_data   <= dec_alu ? result : operand;
            // CP keeps A and only updates F
            if (dec_load || (dec_alu && dec_alu_op != gb_cpu_common_pkg::ALU_CP))
                wr8_reg <= dec_dst;
            else
                wr8_reg <= gb_cpu_common_pkg::REG_NONE;
        end
    end

    // A result carries either an 8-bit write or a pair write
    assert property (@(posedge clk) disable iff (reset)
        ex_valid |-> !(wr8_reg != gb_cpu_common_pkg::REG_NONE && wr16_en));

endmodule

//--- src/gb_cpu_common_pkg.sv
package gb_cpu_common_pkg;

    // 8-bit register codes, 0 to 7 follow the SM83 r field
    localparam logic [3:0] REG_B    = 4'd0;
    localparam logic [3:0] REG_C    = 4'd1;
    localparam logic [3:0] REG_D    = 4'd2;
    localparam logic [3:0] REG_E    = 4'd3;
    localparam logic [3:0] REG_H    = 4'd4;
    localparam logic [3:0] REG_L    = 4'd5;
    localparam logic [3:0] REG_A    = 4'd7;
    // Codes outside the r field
    localparam logic [3:0] REG_F    = 4'd8;
    localparam logic [3:0] REG_SP_H = 4'd9;
    localparam logic [3:0] REG_SP_L = 4'd10;
    // No 8-bit write at all
    localparam logic [3:0] REG_NONE = 4'd15;

    // r field value that names (HL) in memory
    localparam logic [2:0] R_HL_IND = 3'd6;

    // 16-bit pairs, same as the opcode p field
    localparam logic [1:0] PAIR_BC = 2'd0;
    localparam logic [1:0] PAIR_DE = 2'd1;
    localparam logic [1:0] PAIR_HL = 2'd2;
    localparam logic [1:0] PAIR_SP = 2'd3;

    // ALU operations, same as the opcode y field
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_ADC = 3'd1;
    localparam logic [2:0] ALU_SUB = 3'd2;
    localparam logic [2:0] ALU_SBC = 3'd3;
    localparam logic [2:0] ALU_AND = 3'd4;
    localparam logic [2:0] ALU_XOR = 3'd5;
    localparam logic [2:0] ALU_OR  = 3'd6;
    localparam logic [2:0] ALU_CP  = 3'd7;

    // Bit positions in the flag nibble, F keeps it in bits 7:4
    localparam int FLAG_Z = 3;
    localparam int FLAG_N = 2;
    localparam int FLAG_H = 1;
    localparam int FLAG_C = 0;

    // Register contents after the boot ROM hands over
    localparam logic [7:0]  RESET_A  = 8'h01;
    localparam logic [7:0]  RESET_F  = 8'hB0;
    localparam logic [7:0]  RESET_B  = 8'h00;
    localparam logic [7:0]  RESET_C  = 8'h13;
    localparam logic [7:0]  RESET_D  = 8'h00;
    localparam logic [7:0]  RESET_E  = 8'hD8;
    localparam logic [7:0]  RESET_H  = 8'h01;
    localparam logic [7:0]  RESET_L  = 8'h4D;
    localparam logic [15:0] RESET_SP = 16'hFFFE;
    localparam logic [15:0] RESET_PC = 16'h0100;

    // Opcode split as x y z
    typedef struct packed {
        logic [1:0] x;
        logic [2:0] y;
        logic [2:0] z;
    } opcode_xyz_t;

    // Same byte with y split into p and q
    typedef struct packed {
        logic [1:0] x;
        logic [1:0] p;
        logic       q;
        logic [2:0] z;
    } opcode_xpqz_t;

    typedef union packed {
        opcode_xyz_t  xyz;
        opcode_xpqz_t xpqz;
    } opcode_t;

endpackage

//--- src/gb_cpu_core.sv
module gb_cpu_core (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instr_req,
    input  gb_cpu_common_pkg::opcode_t opcode,
    input  logic [7:0]                 imm,
    output logic                       instr_ack,
    output logic                       illegal,
    output logic [7:0]                 a,
    output logic [7:0]                 f,
    output logic [7:0]                 b,
    output logic [7:0]                 c,
    output logic [7:0]                 d,
    output logic [7:0]                 e,
    output logic [7:0]                 h,
    output logic [7:0]                 l,
    output logic [15:0]                sp,
    output logic [15:0]                pc
);

    // Decode to execute
    logic        dec_valid;
    logic        dec_alu;
    logic        dec_load;
    logic        dec_inc16;
    logic        dec_dec16;
    logic        dec_illegal;
    logic        dec_use_imm;
    logic [2:0]  dec_alu_op;
    logic [3:0]  dec_src;
    logic [3:0]  dec_dst;
    logic [1:0]  dec_pair;
    logic [1:0]  dec_len;
    logic [7:0]  dec_imm;

    // Execute to register file
    logic        ex_valid;
    logic        ex_illegal;
    logic        wr16_en;
    logic        flags_en;
    logic [3:0]  wr8_reg;
    logic [7:0]  wr8_data;
    logic [3:0]  flags;
    logic [1:0]  wr16_pair;
    logic [15:0] wr16_data;
    logic [1:0]  ex_len;

    gb_cpu_decode i_gb_cpu_decode (
        .clk, .reset, .instr_req, .instr_ack, .opcode, .imm,
        .dec_valid, .dec_alu, .dec_load, .dec_inc16, .dec_dec16, .dec_illegal,
        .dec_use_imm, .dec_alu_op, .dec_src, .dec_dst, .dec_pair, .dec_len, .dec_imm
    );

    // Operands come straight from the register file outputs
    gb_cpu_alu i_gb_cpu_alu (
        .clk, .reset,
        .dec_valid, .dec_alu, .dec_load, .dec_inc16, .dec_dec16, .dec_illegal,
        .dec_use_imm, .dec_alu_op, .dec_src, .dec_dst, .dec_pair, .dec_len, .dec_imm,
        .a, .f, .b, .c, .d, .e, .h, .l, .sp,
        .ex_valid, .ex_illegal, .wr16_en, .flags_en, .wr8_reg, .wr8_data,
        .flags, .wr16_pair, .wr16_data, .ex_len
    );

    gb_cpu_regfile i_gb_cpu_regfile (
        .clk, .reset, .instr_req,
        .ex_valid, .ex_illegal, .wr8_reg, .wr8_data, .flags_en, .flags,
        .wr16_en, .wr16_pair, .wr16_data, .ex_len,
        .instr_ack, .illegal,
        .a, .f, .b, .c, .d, .e, .h, .l, .sp, .pc
    );

endmodule

//--- src/gb_cpu_decode.sv
module gb_cpu_decode (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instr_req,
    input  logic                       instr_ack,
    input  gb_cpu_common_pkg::opcode_t opcode,
    input  logic [7:0]                 imm,
    output logic                       dec_valid,
    output logic                       dec_alu,
    output logic                       dec_load,
    output logic                       dec_inc16,
    output logic                       dec_dec16,
    output logic                       dec_illegal,
    output logic                       dec_use_imm,
    output logic [2:0]                 dec_alu_op,
    output logic [3:0]                 dec_src,
    output logic [3:0]                 dec_dst,
    output logic [1:0]                 dec_pair,
    output logic [1:0]                 dec_len,
    output logic [7:0]                 dec_imm
);

    // Set from acceptance until the handshake has closed
    logic busy;
    logic accept;

    // Classification of the byte on the port
    logic       c_alu;
    logic       c_load;
    logic       c_inc16;
    logic       c_dec16;
    logic       c_use_imm;
    logic       c_hl_ref;
    logic       c_illegal;
    logic [3:0] c_src;
    logic [3:0] c_dst;

    assign accept = instr_req && !busy;

    always_comb begin
        c_alu     = 1'b0;
        c_load    = 1'b0;
        c_inc16   = 1'b0;
        c_dec16   = 1'b0;
        c_use_imm = 1'b0;
        case (opcode.xyz.x)
            2'd0: begin
                if (opcode.xyz.z == 3'd6) begin
                    // LD r,n
                    c_load    = 1'b1;
                    c_use_imm = 1'b1;
                end else if (opcode.xpqz.z == 3'd3) begin
                    // q picks DEC over INC
                    c_inc16 = !opcode.xpqz.q;
                    c_dec16 = opcode.xpqz.q;
                end
            end
            // LD r,r', 76h falls out through the r field check
            2'd1: c_load = 1'b1;
            // ALU A,r
            2'd2: c_alu = 1'b1;
            default: begin
                // ALU A,n
                c_alu     = opcode.xyz.z == 3'd6;
                c_use_imm = opcode.xyz.z == 3'd6;
            end
        endcase

        // Any (HL) operand needs the memory path
        c_hl_ref = ((c_load || c_alu) && !c_use_imm && opcode.xyz.z == gb_cpu_common_pkg::R_HL_IND)
                   || (c_load && opcode.xyz.y == gb_cpu_common_pkg::R_HL_IND);
        c_illegal = c_hl_ref || !(c_alu || c_load || c_inc16 || c_dec16);

        c_src = c_use_imm ? gb_cpu_common_pkg::REG_NONE : {1'b0, opcode.xyz.z};
        if (c_alu)
            c_dst = gb_cpu_common_pkg::REG_A;
        else if (c_load && !c_illegal)
            c_dst = {1'b0, opcode.xyz.y};
        else
            c_dst = gb_cpu_common_pkg::REG_NONE;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;
            if (accept)
                busy <= 1'b1;
            else if (instr_ack && !instr_req)
                busy <= 1'b0;
        end
    end

    // Fields are held until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_alu     <= c_alu && !c_illegal;
            dec_load    <= c_load && !c_illegal;
            dec_inc16   <= c_inc16;
            dec_dec16   <= c_dec16;
            dec_illegal <= c_illegal;
            dec_use_imm <= c_use_imm;
            dec_alu_op  <= opcode.xyz.y;
            dec_src     <= c_src;
            dec_dst     <= c_dst;
            dec_pair    <= opcode.xpqz.p;
            dec_len     <= c_use_imm ? 2'd2 : 2'd1;
            dec_imm     <= imm;
        end
    end

    // Execute gets exactly one kind of work, or none when illegal
    assert property (@(posedge clk) disable iff (reset)
        dec_valid |-> $onehot({dec_alu, dec_load, dec_inc16, dec_dec16, dec_illegal}));

endmodule

//--- src/gb_cpu_regfile.sv
module gb_cpu_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_req,
    input  logic        ex_valid,
    input  logic        ex_illegal,
    input  logic [3:0]  wr8_reg,
    input  logic [7:0]  wr8_data,
    input  logic        flags_en,
    input  logic [3:0]  flags,
    input  logic        wr16_en,
    input  logic [1:0]  wr16_pair,
    input  logic [15:0] wr16_data,
    input  logic [1:0]  ex_len,
    output logic        instr_ack,
    output logic        illegal,
    output logic [7:0]  a,
    output logic [7:0]  f,
    output logic [7:0]  b,
    output logic [7:0]  c,
    output logic [7:0]  d,
    output logic [7:0]  e,
    output logic [7:0]  h,
    output logic [7:0]  l,
    output logic [15:0] sp,
    output logic [15:0] pc
);

    // Write strobes for a legal result
    logic       commit;
    logic       wr8_go;
    logic       wr16_go;
    // Pair write split into two 8-bit codes
    logic [3:0] wr16_hi;
    logic [3:0] wr16_lo;

    assign commit  = ex_valid && !ex_illegal;
    assign wr8_go  = commit && wr8_reg != gb_cpu_common_pkg::REG_NONE;
    assign wr16_go = commit && wr16_en;

    always_comb begin
        case (wr16_pair)
            gb_cpu_common_pkg::PAIR_BC: begin
                wr16_hi = gb_cpu_common_pkg::REG_B;
                wr16_lo = gb_cpu_common_pkg::REG_C;
            end
            gb_cpu_common_pkg::PAIR_DE: begin
                wr16_hi = gb_cpu_common_pkg::REG_D;
                wr16_lo = gb_cpu_common_pkg::REG_E;
            end
            gb_cpu_common_pkg::PAIR_HL: begin
                wr16_hi = gb_cpu_common_pkg::REG_H;
                wr16_lo = gb_cpu_common_pkg::REG_L;
            end
            default: begin
                wr16_hi = gb_cpu_common_pkg::REG_SP_H;
                wr16_lo = gb_cpu_common_pkg::REG_SP_L;
            end
        endcase
    end

    // Fixed priority, the 8-bit write wins over the pair write
    function automatic logic [7:0] next8(input logic [7:0] cur, input logic [3:0] code);
        logic [7:0] val;
        val = cur;
        if (wr16_go && code == wr16_lo)
            val = wr16_data[7:0];
        if (wr16_go && code == wr16_hi)
            val = wr16_data[15:8];
        if (wr8_go && code == wr8_reg)
            val = wr8_data;
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            a  <= gb_cpu_common_pkg::RESET_A;
            f  <= gb_cpu_common_pkg::RESET_F;
            b  <= gb_cpu_common_pkg::RESET_B;
            c  <= gb_cpu_common_pkg::RESET_C;
            d  <= gb_cpu_common_pkg::RESET_D;
            e  <= gb_cpu_common_pkg::RESET_E;
            h  <= gb_cpu_common_pkg::RESET_H;
            l  <= gb_cpu_common_pkg::RESET_L;
            sp <= gb_cpu_common_pkg::RESET_SP;
            pc <= gb_cpu_common_pkg::RESET_PC;
        end else begin
            a  <= next8(a, gb_cpu_common_pkg::REG_A);
            b  <= next8(b, gb_cpu_common_pkg::REG_B);
            c  <= next8(c, gb_cpu_common_pkg::REG_C);
            d  <= next8(d, gb_cpu_common_pkg::REG_D);
            e  <= next8(e, gb_cpu_common_pkg::REG_E);
            h  <= next8(h, gb_cpu_common_pkg::REG_H);
            l  <= next8(l, gb_cpu_common_pkg::REG_L);
            sp <= {next8(sp[15:8], gb_cpu_common_pkg::REG_SP_H),
                   next8(sp[7:0], gb_cpu_common_pkg::REG_SP_L)};
            // Low nibble of F stays zero
            if (wr8_go && wr8_reg == gb_cpu_common_pkg::REG_F)
                f <= {wr8_data[7:4], 4'h0};
            else if (commit && flags_en)
                f <= {flags, 4'h0};
            // Illegal opcodes leave PC where it was
            if (commit)
                pc <= pc + {14'd0, ex_len};
        end
    end

    // Ack rises with the write and drops once the request is gone
    always_ff @(posedge clk) begin
        if (reset) begin
            instr_ack <= 1'b0;
            illegal   <= 1'b0;
        end else if (ex_valid) begin
            instr_ack <= 1'b1;
            illegal   <= ex_illegal;
        end else if (!instr_req) begin
            instr_ack <= 1'b0;
            illegal   <= 1'b0;
        end
    end

    // Four-phase order on the outside port
    assert property (@(posedge clk) disable iff (reset)
        $fell(instr_ack) |-> !$past(instr_req));

    // Decode holds off until the previous handshake has closed
    assert property (@(posedge clk) disable iff (reset)
        ex_valid |-> !instr_ack);

endmodule

//--- tests/gb_cpu_core_checker.sv
module gb_cpu_core_checker (
    input logic        clk,
    input logic        reset,
    input logic        instr_req,
    input logic [7:0]  opcode,
    input logic [7:0]  imm,
    input logic        instr_ack,
    input logic        illegal,
    input logic [7:0]  a,
    input logic [7:0]  f,
    input logic [7:0]  b,
    input logic [7:0]  c,
    input logic [7:0]  d,
    input logic [7:0]  e,
    input logic [7:0]  h,
    input logic [7:0]  l,
    input logic [15:0] sp,
    input logic [15:0] pc
);

    // Model registers in r field order, A sits at index 7
    logic [7:0]  m_r [0:7];
    logic [7:0]  m_f;
    logic [15:0] m_sp;
    logic [15:0] m_pc;

    // Handshake tracking, all sampled on the rising edge
    logic       req_prev;
    logic       ack_prev;
    logic       after_reset;
    logic       fall_due;
    logic       pending;
    logic       exp_illegal;
    int         edges;
    logic [7:0] cap_op;
    logic [7:0] cap_imm;

    // Counters per test group and overall
    string group_name   = "none";
    int    group_checks = 0;
    int    group_errors = 0;
    int    check_count  = 0;
    int    error_count  = 0;
    int    test_count   = 0;

    task automatic start_group(input string name);
        group_name   = name;
        group_checks = 0;
        group_errors = 0;
    endtask

    task automatic end_group();
        test_count = test_count + 1;
        $display("Test %s: %0d checks, %0d errors", group_name, group_checks, group_errors);
    endtask

    task automatic print_counts();
        $display("Totals: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
    endtask

    task automatic check_value(input string what, input logic [15:0] exp,
                               input logic [15:0] act);
        check_count  = check_count + 1;
        group_checks = group_checks + 1;
        if (exp !== act) begin
            $display("Mismatch %s op %h %s: expected %h, actual %h",
                     group_name, cap_op, what, exp, act);
            error_count  = error_count + 1;
            group_errors = group_errors + 1;
        end
    endtask

    task automatic report_error(input string msg);
        $display("Error in %s: %s", group_name, msg);
        error_count  = error_count + 1;
        group_errors = group_errors + 1;
    endtask

    // Post-boot register values
    task automatic reset_model();
        m_r[0] = gb_cpu_common_pkg::RESET_B;
        m_r[1] = gb_cpu_common_pkg::RESET_C;
        m_r[2] = gb_cpu_common_pkg::RESET_D;
        m_r[3] = gb_cpu_common_pkg::RESET_E;
        m_r[4] = gb_cpu_common_pkg::RESET_H;
        m_r[5] = gb_cpu_common_pkg::RESET_L;
        m_r[6] = 8'h00;
        m_r[7] = gb_cpu_common_pkg::RESET_A;
        m_f    = gb_cpu_common_pkg::RESET_F;
        m_sp   = gb_cpu_common_pkg::RESET_SP;
        m_pc   = gb_cpu_common_pkg::RESET_PC;
    endtask

    // 8-bit ALU on A, flags as Z N H C in the upper nibble
    function automatic void ref_alu(input logic [2:0] op, input logic [7:0] v);
        int         acc;
        int         vi;
        int         cy;
        int         sum;
        int         lo;
        logic       nf;
        logic       hf;
        logic       cf;
        logic [7:0] res;
        acc = m_r[7];
        vi  = v;
        cy  = (op == 3'd1 || op == 3'd3) ? int'(m_f[4]) : 0;
        nf  = 1'b0;
        hf  = 1'b0;
        cf  = 1'b0;
        case (op)
            3'd0, 3'd1: begin
                sum = acc + vi + cy;
                lo  = (acc & 15) + (vi & 15) + cy;
                res = 8'(sum);
                hf  = lo > 15;
                cf  = sum > 255;
            end
            3'd2, 3'd3, 3'd7: begin
                // Borrows show up as negative differences
                sum = acc - vi - cy;
                lo  = (acc & 15) - (vi & 15) - cy;
                res = 8'(sum);
                nf  = 1'b1;
                hf  = lo < 0;
                cf  = sum < 0;
            end
            3'd4: begin
                res = m_r[7] & v;
                hf  = 1'b1;
            end
            3'd5: res = m_r[7] ^ v;
            default: res = m_r[7] | v;
        endcase
        m_f = {res == 8'h00, nf, hf, cf, 4'h0};
        // CP only touches F
        if (op != 3'd7)
            m_r[7] = res;
    endfunction

    // Next model state for one instruction, returns the illegal flag
    function automatic logic ref_step(input logic [7:0] op, input logic [7:0] n);
        logic [1:0]  x;
        logic [2:0]  y;
        logic [2:0]  z;
        logic [15:0] pair;
        logic        bad;
        x   = op[7:6];
        y   = op[5:3];
        z   = op[2:0];
        bad = 1'b0;
        if (x == 2'd1 && y != 3'd6 && z != 3'd6) begin
            m_r[y] = m_r[z];
            m_pc   = m_pc + 16'd1;
        end else if (x == 2'd0 && z == 3'd6 && y != 3'd6) begin
            m_r[y] = n;
            m_pc   = m_pc + 16'd2;
        end else if (x == 2'd2 && z != 3'd6) begin
            ref_alu(y, m_r[z]);
            m_pc = m_pc + 16'd1;
        end else if (x == 2'd3 && z == 3'd6) begin
            ref_alu(y, n);
            m_pc = m_pc + 16'd2;
        end else if (x == 2'd0 && z == 3'd3) begin
            case (op[5:4])
                2'd0: pair = {m_r[0], m_r[1]};
                2'd1: pair = {m_r[2], m_r[3]};
                2'd2: pair = {m_r[4], m_r[5]};
                default: pair = m_sp;
            endcase
            // Bit 3 selects DEC
            pair = op[3] ? pair - 16'd1 : pair + 16'd1;
            case (op[5:4])
                2'd0: {m_r[0], m_r[1]} = pair;
                2'd1: {m_r[2], m_r[3]} = pair;
                2'd2: {m_r[4], m_r[5]} = pair;
                default: m_sp = pair;
            endcase
            m_pc = m_pc + 16'd1;
        end else begin
            bad = 1'b1;
        end
        return bad;
    endfunction

    task automatic compare_state(input logic exp_ill);
        check_value("illegal", exp_ill, illegal);
        check_value("A", m_r[7], a);
        check_value("F", m_f, f);
        check_value("B", m_r[0], b);
        check_value("C", m_r[1], c);
        check_value("D", m_r[2], d);
        check_value("E", m_r[3], e);
        check_value("H", m_r[4], h);
        check_value("L", m_r[5], l);
        check_value("SP", m_sp, sp);
        check_value("PC", m_pc, pc);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            reset_model();
            after_reset = 1'b1;
            req_prev    = 1'b0;
            ack_prev    = 1'b0;
            fall_due    = 1'b0;
            pending     = 1'b0;
            edges       = 0;
            cap_op      = 8'h00;
            cap_imm     = 8'h00;
        end else begin
            // First edge out of reset
            if (after_reset) begin
                compare_state(1'b0);
                check_value("instr_ack", 1'b0, instr_ack);
                after_reset = 1'b0;
            end
            if (fall_due && instr_ack)
                report_error("instr_ack still high one edge after instr_req went low");
            if (ack_prev && req_prev && !instr_ack)
                report_error("instr_ack dropped while instr_req was still high");
            if (instr_ack && !ack_prev && !pending)
                report_error("instr_ack rose with no request outstanding");
            // New request, this is the accepting edge
            if (instr_req && !req_prev && !instr_ack) begin
                cap_op  = opcode;
                cap_imm = imm;
                pending = 1'b1;
                edges   = 1;
            end else if (pending && !instr_ack) begin
                edges = edges + 1;
            end
            if (pending && instr_ack) begin
                check_value("ack latency", 16'd3, edges);
                exp_illegal = ref_step(cap_op, cap_imm);
                compare_state(exp_illegal);
                pending = 1'b0;
            end
            fall_due = instr_ack && !instr_req;
            req_prev = instr_req;
            ack_prev = instr_ack;
        end
    end

endmodule

//--- tests/gb_cpu_core_tb.sv
module gb_cpu_core_tb;

    localparam int NUM_DIRECTED = 88;
    localparam int NUM_RANDOM   = 300;
    // Eight cycles per instruction plus slack for reset
    localparam int CYCLE_LIMIT  = (NUM_DIRECTED + NUM_RANDOM) * 8 + 100;

    logic                       clk;
    logic                       reset;
    logic                       instr_req;
    gb_cpu_common_pkg::opcode_t opcode;
    logic [7:0]                 imm;
    logic                       instr_ack;
    logic                       illegal;
    logic [7:0]                 a;
    logic [7:0]                 f;
    logic [7:0]                 b;
    logic [7:0]                 c;
    logic [7:0]                 d;
    logic [7:0]                 e;
    logic [7:0]                 h;
    logic [7:0]                 l;
    logic [15:0]                sp;
    logic [15:0]                pc;

    // Directed list as group, opcode, immediate
    logic [19:0] directed [0:NUM_DIRECTED-1];
    logic [3:0]  cur_group;
    logic [31:0] rnd;
    integer      seed;
    int          cycles;

    gb_cpu_core i_gb_cpu_core (
        .clk, .reset, .instr_req, .opcode, .imm, .instr_ack, .illegal,
        .a, .f, .b, .c, .d, .e, .h, .l, .sp, .pc
    );

    gb_cpu_core_checker i_gb_cpu_core_checker (
        .clk, .reset, .instr_req, .opcode, .imm, .instr_ack, .illegal,
        .a, .f, .b, .c, .d, .e, .h, .l, .sp, .pc
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic string group_label(input logic [3:0] g);
        case (g)
            4'd1: return "load";
            4'd2: return "alu";
            4'd3: return "inc_dec";
            4'd4: return "illegal";
            default: return "unknown";
        endcase
    endfunction

    // One full four-phase handshake, entered and left on a falling edge
    task automatic send_instr(input logic [7:0] op, input logic [7:0] n);
        opcode    = op;
        imm       = n;
        instr_req = 1'b1;
        @(negedge clk);
        while (!instr_ack)
            @(negedge clk);
        // Request stays up one more edge so ack has to hold
        @(negedge clk);
        instr_req = 1'b0;
        @(negedge clk);
        while (instr_ack)
            @(negedge clk);
    endtask

    initial begin
        reset     = 1'b1;
        instr_req = 1'b0;
        opcode    = 8'h00;
        imm       = 8'h00;
        seed      = 32'h8a3c_34ca;
        directed = '{
            // LD r,n then LD r,r'
            20'h1_0612, 20'h1_0E34, 20'h1_1656, 20'h1_1E78, 20'h1_269A, 20'h1_2EBC,
            20'h1_3EDE, 20'h1_4100, 20'h1_4A00, 20'h1_5300, 20'h1_5C00, 20'h1_6500,
            20'h1_6F00, 20'h1_7800, 20'h1_7D00, 20'h1_7F00, 20'h1_4000,
            // Carry and half carry edges, then borrows
            20'h2_3EFF, 20'h2_C601, 20'h2_3E0F, 20'h2_C601, 20'h2_3E80, 20'h2_C680,
            20'h2_CEFF, 20'h2_3E00, 20'h2_D601, 20'h2_DE00, 20'h2_3E10, 20'h2_D601,
            // Logic ops, CP with immediate and CP A,A
            20'h2_3EF0, 20'h2_E60F, 20'h2_EEFF, 20'h2_F600, 20'h2_FE12, 20'h2_BF00,
            // Register operand forms
            20'h2_063C, 20'h2_0EC5, 20'h2_8000, 20'h2_8800, 20'h2_9100, 20'h2_9900,
            20'h2_A000, 20'h2_A900, 20'h2_B100, 20'h2_B800, 20'h2_AF00, 20'h2_B700,
            20'h2_8700, 20'h2_8F00, 20'h2_9700, 20'h2_9F00, 20'h2_A700,
            // Pairs wrapping at FFFF and 0000
            20'h3_06FF, 20'h3_0EFF, 20'h3_0300, 20'h3_0B00, 20'h3_0B00, 20'h3_1600,
            20'h3_1E00, 20'h3_1B00, 20'h3_1300, 20'h3_2612, 20'h3_2EFF, 20'h3_2300,
            20'h3_2B00, 20'h3_3300, 20'h3_3300, 20'h3_3B00, 20'h3_3B00,
            // (HL) forms, HALT, CB prefix and other unsupported opcodes
            20'h4_7600, 20'h4_4600, 20'h4_4E00, 20'h4_7000, 20'h4_7700, 20'h4_3655,
            20'h4_8600, 20'h4_9600, 20'h4_BE00, 20'h4_3400, 20'h4_3500, 20'h4_0400,
            20'h4_0000, 20'h4_C300, 20'h4_CB00, 20'h4_E900, 20'h4_D300, 20'h4_F300,
            20'h4_1000
        };

        // Reset for two rising edges, released on a falling edge
        i_gb_cpu_core_checker.start_group("reset");
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);
        i_gb_cpu_core_checker.end_group();

        cur_group = 4'd0;
        for (int i = 0; i < NUM_DIRECTED; i++) begin
            if (directed[i][19:16] != cur_group) begin
                if (cur_group != 4'd0)
                    i_gb_cpu_core_checker.end_group();
                cur_group = directed[i][19:16];
                i_gb_cpu_core_checker.start_group(group_label(cur_group));
            end
            send_instr(directed[i][15:8], directed[i][7:0]);
        end
        i_gb_cpu_core_checker.end_group();

        // Random opcode and immediate pairs
        i_gb_cpu_core_checker.start_group("random");
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            send_instr(rnd[15:8], rnd[7:0]);
        end
        i_gb_cpu_core_checker.end_group();

        i_gb_cpu_core_checker.print_counts();
        if (i_gb_cpu_core_checker.error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Done: errors found");
        $finish;
    end

endmodule
